//--- hw/fetch_pkg.sv
// Fetch bus types and buffer sizing for the alignment buffer
// Instruction words are 32 bits, little endian, halfword granular
// Buffer depth and outstanding limit are fixed; the throttling
// logic is only correct for exactly three entries and two requests

`default_nettype none

package fetch_pkg;

  //////////////////////////////
  // Bus response
  //////////////////////////////

  // One response word from the instruction bus
  typedef struct packed {
    logic [31:0] rdata;
    logic        err;
  } fetch_resp_t;

  //////////////////////////////
  // Buffer sizing
  //////////////////////////////

  // Response buffer entries
  localparam int FIFO_DEPTH = 3;

  // Requests allowed in flight at once
  localparam int MAX_OUTSTANDING = 2;

  // Width of buffer pointers and outstanding counter
  localparam int PTR_W = 2;

  //////////////////////////////
  // Instruction format
  //////////////////////////////

  // Low two bits of a halfword that starts a 32-bit instruction
  // Any other value starts a compressed one
  localparam logic [1:0] LEN_FULL = 2'b11;

endpackage : fetch_pkg

`default_nettype wire

//--- hw/ctrl_pkg.sv
// Pipeline control types seen by the fetch alignment buffer
// A branch is pc_set and kill_if high together for one cycle

`default_nettype none

package ctrl_pkg;

  //////////////////////////////
  // Controller command
  //////////////////////////////

  typedef struct packed {
    // Fetching is wanted by the core
    logic instr_req;
    // Load a new fetch address from branch_addr_i
    logic pc_set;
    // Drop everything buffered or in flight
    logic kill_if;
  } fetch_ctrl_t;

endpackage : ctrl_pkg

`default_nettype wire

//--- hw/fetch_ctrl.sv
// Request throttling and response bookkeeping for the alignment buffer
// instr_req must stay low until the first branch after reset
// Responses must come in order, at most one per cycle, one per request
// The instruction count lags a pop by one cycle to keep ready off the
// request path

`default_nettype none

module fetch_ctrl import fetch_pkg::*, ctrl_pkg::*; (
  input  wire logic                                 clk,
  input  wire logic                                 rst_n,
  input  wire fetch_ctrl_t                          ctrl_i,
  input  wire logic [31:0]                          branch_addr_i,
  input  wire logic                                 fetch_ready_i,
  input  wire logic                                 resp_valid_i,
  input  wire fetch_resp_t                          resp_i,
  input  wire logic                                 pop_i,
  output logic                                      fetch_valid_o,
  output logic                                      resp_valid_gated_o,
  output logic [$clog2(2*FIFO_DEPTH+1)-1:0]         buf_level_o
);

  // Up to two instructions per buffered word
  localparam int CNT_W = $clog2(2*FIFO_DEPTH+1);

  // Where the next response word starts relative to instruction boundaries
  typedef enum logic [1:0] {
    PARSE_ALIGNED,  // Word starts on an instruction boundary
    PARSE_SKIP_LOW, // Unaligned branch, low half is not used
    PARSE_SPLIT     // Low half ends a straddling instruction
  } parse_state_e;

  parse_state_e     parse_q, parse_n;
  logic [CNT_W-1:0] instr_cnt_q, instr_cnt_n, instr_avail;
  logic [PTR_W-1:0] outstanding_q, outstanding_n;
  logic [PTR_W-1:0] n_flush_q, n_flush_n;
  logic [1:0]       n_incoming;
  logic             pop_q;
  logic             req_accept;
  logic             lo_full, hi_full;

  //////////////////////////////
  // Request throttling
  //////////////////////////////

  // Instructions left after the pop of last cycle
  assign instr_avail = instr_cnt_q - CNT_W'(pop_q);

  // Refill when empty, or nearly empty with nothing in flight
  // A branch always requests, the buffer is being dropped anyway
  assign fetch_valid_o = ctrl_i.instr_req &&
                         (outstanding_q < PTR_W'(MAX_OUTSTANDING)) &&
                         ((instr_avail == '0) ||
                          ((instr_avail == CNT_W'(1)) && (outstanding_q == '0)) ||
                          ctrl_i.pc_set);

  assign req_accept = fetch_valid_o && fetch_ready_i;

  // Stale responses from before a branch never reach the buffer
  assign resp_valid_gated_o = (n_flush_q != '0) ? 1'b0 : resp_valid_i;

  assign buf_level_o = instr_cnt_q;

  //////////////////////////////
  // Outstanding and flush counts
  //////////////////////////////

  always_comb begin
    outstanding_n = outstanding_q;
    if (req_accept && !resp_valid_i) begin
      outstanding_n = outstanding_q + PTR_W'(1);
    end else if (!req_accept && resp_valid_i) begin
      outstanding_n = outstanding_q - PTR_W'(1);
    end
  end

  always_comb begin
    n_flush_n = n_flush_q;
    if (ctrl_i.pc_set) begin
      // Everything in flight belongs to the old path
      // A response in this very cycle is already dropped by the kill
      n_flush_n = outstanding_q - PTR_W'(resp_valid_i);
    end else if (resp_valid_i && (n_flush_q != '0)) begin
      n_flush_n = n_flush_q - PTR_W'(1);
    end
  end

  //////////////////////////////
  // Incoming instruction tracker
  //////////////////////////////

  assign lo_full = (resp_i.rdata[1:0] == LEN_FULL);
  assign hi_full = (resp_i.rdata[17:16] == LEN_FULL);

  always_comb begin
    parse_n    = parse_q;
    n_incoming = 2'd0;
    if (ctrl_i.pc_set) begin
      parse_n = branch_addr_i[1] ? PARSE_SKIP_LOW : PARSE_ALIGNED;
    end else if (resp_valid_gated_o) begin
      unique case (parse_q)
        PARSE_ALIGNED: begin
          if (lo_full) begin
            // One full instruction fills the word
            n_incoming = 2'd1;
          end else if (hi_full) begin
            // Compressed low, full one starts in the upper half
            n_incoming = 2'd1;
            parse_n    = PARSE_SPLIT;
          end else begin
            n_incoming = 2'd2;
          end
        end
        PARSE_SKIP_LOW: begin
          if (hi_full) begin
            n_incoming = 2'd0;
            parse_n    = PARSE_SPLIT;
          end else begin
            n_incoming = 2'd1;
            parse_n    = PARSE_ALIGNED;
          end
        end
        PARSE_SPLIT: begin
          // Low half completes the previous instruction
          if (hi_full) begin
            n_incoming = 2'd1;
          end else begin
            n_incoming = 2'd2;
            parse_n    = PARSE_ALIGNED;
          end
        end
        default: begin
          parse_n = PARSE_ALIGNED;
        end
      endcase
    end
  end

  always_comb begin
    if (ctrl_i.kill_if) begin
      instr_cnt_n = '0;
    end else begin
      instr_cnt_n = instr_cnt_q + CNT_W'(n_incoming) - CNT_W'(pop_q);
    end
  end

  //////////////////////////////
  // Registers
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      parse_q       <= PARSE_ALIGNED;
      instr_cnt_q   <= '0;
      outstanding_q <= '0;
      n_flush_q     <= '0;
      pop_q         <= 1'b0;
    end else begin
      parse_q       <= parse_n;
      instr_cnt_q   <= instr_cnt_n;
      outstanding_q <= outstanding_n;
      n_flush_q     <= n_flush_n;
      pop_q         <= pop_i;
    end
  end

  //////////////////////////////
  // Assertions
  //////////////////////////////

  // Throttling keeps the bus within its limit over any request sequence
  a_outstanding_max: assert property (@(posedge clk) disable iff (!rst_n)
    outstanding_q <= PTR_W'(MAX_OUTSTANDING));

  // The bus answers only requests it accepted
  a_resp_has_req: assert property (@(posedge clk) disable iff (!rst_n)
    resp_valid_i |-> (outstanding_q != '0));

endmodule : fetch_ctrl

`default_nettype wire

//--- hw/resp_fifo.sv
// Three-entry buffer of bus response words
// The two oldest words are presented side by side for the aligner
// A branch resets both pointers; kill_if empties the buffer
// Overflow is prevented by the request throttling upstream

`default_nettype none

module resp_fifo import fetch_pkg::*, ctrl_pkg::*; (
  input  wire logic        clk,
  input  wire logic        rst_n,
  input  wire fetch_ctrl_t ctrl_i,
  input  wire logic        resp_valid_gated_i,
  input  wire fetch_resp_t resp_i,
  input  wire logic        pop_i,
  input  wire logic        word_done_i,
  output logic             head_valid_o,
  output fetch_resp_t      head_resp_o,
  output logic             next_valid_o,
  output fetch_resp_t      next_resp_o
);

  fetch_resp_t            mem_q [FIFO_DEPTH];
  logic [FIFO_DEPTH-1:0]  valid_q, valid_n;
  logic [PTR_W-1:0]       wptr_q, rptr_q, rptr_next;
  logic                   write;
  logic                   release_head;

  // Step a pointer, wrapping at the last entry
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
      return '0;
    end
    return ptr + PTR_W'(1);
  endfunction

  // Writes are dropped in the kill cycle
  assign write        = resp_valid_gated_i && !ctrl_i.kill_if;
  assign release_head = pop_i && word_done_i;

  assign rptr_next = ptr_inc(rptr_q);

  //////////////////////////////
  // Read side
  //////////////////////////////

  assign head_valid_o = valid_q[rptr_q];
  assign head_resp_o  = mem_q[rptr_q];
  assign next_valid_o = valid_q[rptr_next];
  assign next_resp_o  = mem_q[rptr_next];

  //////////////////////////////
  // Valid bits
  //////////////////////////////

  always_comb begin
    valid_n = valid_q;
    // Set before clear, so a word used straight from the bus never stays
    if (write) begin
      valid_n[wptr_q] = 1'b1;
    end
    if (release_head) begin
      valid_n[rptr_q] = 1'b0;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
      wptr_q  <= '0;
      rptr_q  <= '0;
    end else begin
      if (ctrl_i.kill_if) begin
        valid_q <= '0;
      end else begin
        valid_q <= valid_n;
      end

      if (ctrl_i.pc_set) begin
        wptr_q <= '0;
        rptr_q <= '0;
      end else begin
        if (write) begin
          wptr_q <= ptr_inc(wptr_q);
        end
        if (release_head) begin
          rptr_q <= rptr_next;
        end
      end
    end
  end

  // Payload storage
  always_ff @(posedge clk) begin
    if (write) begin
      mem_q[wptr_q] <= resp_i;
    end
  end

  //////////////////////////////
  // Assertions
  //////////////////////////////

  // Throttling upstream leaves a free entry for every response
  a_no_overwrite: assert property (@(posedge clk) disable iff (!rst_n)
    write |-> (!valid_q[wptr_q] && ($countones(valid_q) <= MAX_OUTSTANDING)));

endmodule : resp_fifo

`default_nettype wire

//--- hw/instr_aligner.sv
// Builds one 16- or 32-bit instruction per handshake from buffered words
// An aligned instruction sits in the head word or the incoming one
// An unaligned one joins the upper half of the head with the next word
// Output data and address hold while instr_ready_i is low

`default_nettype none

module instr_aligner import fetch_pkg::*, ctrl_pkg::*; (
  input  wire logic        clk,
  input  wire logic        rst_n,
  input  wire fetch_ctrl_t ctrl_i,
  input  wire logic [31:0] branch_addr_i,
  input  wire logic        resp_valid_gated_i,
  input  wire fetch_resp_t resp_i,
  input  wire logic        head_valid_i,
  input  wire fetch_resp_t head_resp_i,
  input  wire logic        next_valid_i,
  input  wire fetch_resp_t next_resp_i,
  input  wire logic [2:0]  buf_level_i,
  input  wire logic        instr_ready_i,
  output logic             instr_valid_o,
  output fetch_resp_t      instr_o,
  output logic [31:0]      instr_addr_o,
  output logic             pop_o,
  output logic             word_done_o
);

  logic [31:0] addr_q;
  logic [31:0] low_word;
  logic        low_err;
  logic [15:0] high_half;
  logic        high_err;
  logic        any_valid, split_valid;
  logic        aligned_is_c, unaligned_is_c, is_c;

  //////////////////////////////
  // Source selection
  //////////////////////////////

  // Word holding the instruction start, from buffer or straight from bus
  assign low_word = head_valid_i ? head_resp_i.rdata : resp_i.rdata;
  assign low_err  = head_valid_i ? head_resp_i.err   : resp_i.err;

  // Lower half of the following word for a straddling instruction
  assign high_half = next_valid_i ? next_resp_i.rdata[15:0] : resp_i.rdata[15:0];
  assign high_err  = next_valid_i ? next_resp_i.err         : resp_i.err;

  assign any_valid = head_valid_i || resp_valid_gated_i;
  // Both words present, head is always filled before next
  assign split_valid = next_valid_i || (head_valid_i && resp_valid_gated_i);

  // Only meaningful while any_valid is high
  assign aligned_is_c   = (low_word[1:0]   != LEN_FULL);
  assign unaligned_is_c = (low_word[17:16] != LEN_FULL);
  assign is_c           = addr_q[1] ? unaligned_is_c : aligned_is_c;

  //////////////////////////////
  // Output path
  //////////////////////////////

  always_comb begin
    instr_o.rdata = low_word;
    instr_o.err   = low_err;
    instr_valid_o = 1'b0;
    if (ctrl_i.kill_if) begin
      // Nothing leaves in the branch cycle
      instr_valid_o = 1'b0;
    end else if (addr_q[1]) begin
      instr_o.rdata = {high_half, low_word[31:16]};
      // Err from every word the instruction touches
      instr_o.err   = low_err || (!unaligned_is_c && high_err);
      if (unaligned_is_c) begin
        instr_valid_o = any_valid;
      end else begin
        instr_valid_o = split_valid;
      end
    end else begin
      instr_valid_o = any_valid;
    end
  end

  assign instr_addr_o = addr_q;

  assign pop_o = instr_valid_o && instr_ready_i;

  // Instruction ends the head word, so the buffer can release it
  assign word_done_o = addr_q[1] || !aligned_is_c;

  //////////////////////////////
  // Instruction address
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_q <= '0;
    end else if (ctrl_i.pc_set) begin
      addr_q <= branch_addr_i;
    end else if (pop_o) begin
      // Halfword granular step over the consumed instruction
      addr_q <= addr_q + (is_c ? 32'd2 : 32'd4);
    end
  end

  //////////////////////////////
  // Assertions
  //////////////////////////////

  // No instruction from the old path in the branch cycle
  a_kill_no_valid: assert property (@(posedge clk) disable iff (!rst_n)
    ctrl_i.kill_if |-> !instr_valid_o);

  // An instruction offered from the buffer alone was counted by fetch_ctrl
  a_buf_counted: assert property (@(posedge clk) disable iff (!rst_n)
    (instr_valid_o && !resp_valid_gated_i) |-> (buf_level_i != 3'd0));

endmodule : instr_aligner

`default_nettype wire

//--- hw/align_buf_top.sv
// Fetch alignment buffer top level
// The prefetcher takes the branch target from the controller directly
// and steps by one word per accepted request

`default_nettype none

module align_buf_top import fetch_pkg::*, ctrl_pkg::*; (
  input  wire logic        clk,
  input  wire logic        rst_n,
  // Controller command
  input  wire fetch_ctrl_t ctrl_i,
  input  wire logic [31:0] branch_addr_i,
  // Fetch request
  output logic             fetch_valid_o,
  input  wire logic        fetch_ready_i,
  // Fetch response
  input  wire logic        resp_valid_i,
  input  wire fetch_resp_t resp_i,
  // Instruction output
  output logic             instr_valid_o,
  input  wire logic        instr_ready_i,
  output fetch_resp_t      instr_o,
  output logic [31:0]      instr_addr_o
);

  logic        resp_valid_gated;
  logic [2:0]  buf_level;
  logic        pop;
  logic        word_done;
  logic        head_valid;
  fetch_resp_t head_resp;
  logic        next_valid;
  fetch_resp_t next_resp;

  // Request throttling and instruction counting
  fetch_ctrl u_fetch_ctrl (
    .clk                (clk),
    .rst_n              (rst_n),
    .ctrl_i             (ctrl_i),
    .branch_addr_i      (branch_addr_i),
    .fetch_ready_i      (fetch_ready_i),
    .resp_valid_i       (resp_valid_i),
    .resp_i             (resp_i),
    .pop_i              (pop),
    .fetch_valid_o      (fetch_valid_o),
    .resp_valid_gated_o (resp_valid_gated),
    .buf_level_o        (buf_level)
  );

  // Word storage
  resp_fifo u_resp_fifo (
    .clk                (clk),
    .rst_n              (rst_n),
    .ctrl_i             (ctrl_i),
    .resp_valid_gated_i (resp_valid_gated),
    .resp_i             (resp_i),
    .pop_i              (pop),
    .word_done_i        (word_done),
    .head_valid_o       (head_valid),
    .head_resp_o        (head_resp),
    .next_valid_o       (next_valid),
    .next_resp_o        (next_resp)
  );

  // Instruction assembly and output handshake
  instr_aligner u_instr_aligner (
    .clk                (clk),
    .rst_n              (rst_n),
    .ctrl_i             (ctrl_i),
    .branch_addr_i      (branch_addr_i),
    .resp_valid_gated_i (resp_valid_gated),
    .resp_i             (resp_i),
    .head_valid_i       (head_valid),
    .head_resp_i        (head_resp),
    .next_valid_i       (next_valid),
    .next_resp_i        (next_resp),
    .buf_level_i        (buf_level),
    .instr_ready_i      (instr_ready_i),
    .instr_valid_o      (instr_valid_o),
    .instr_o            (instr_o),
    .instr_addr_o       (instr_addr_o),
    .pop_o              (pop),
    .word_done_o        (word_done)
  );

endmodule : align_buf_top

`default_nettype wire

//--- tb/align_buf_tb.sv
// Testbench for the fetch alignment buffer
// Bus model answers in order with 1 to 3 cycles of latency, fetch ready always high
// Program memory is 32 words and wraps, so addresses are taken modulo 128 bytes
// Compressed instructions are compared on their low 16 bits only

`default_nettype none

module align_buf_tb
  import fetch_pkg::*, ctrl_pkg::*;
();

  localparam int N_ROWS = 7;

  typedef struct {
    string       name;
    logic [31:0] target;
    int          count;
    int          stall;
    int          err_word;
  } test_row_t;

  logic        clk = 1'b0;
  logic        rst_n;
  fetch_ctrl_t ctrl_i;
  logic [31:0] branch_addr_i;
  logic        fetch_valid_o;
  logic        fetch_ready_i;
  logic        resp_valid_i;
  fetch_resp_t resp_i;
  logic        instr_valid_o;
  logic        instr_ready_i;
  fetch_resp_t instr_o;
  logic [31:0] instr_addr_o;

  test_row_t   rows [N_ROWS];
  logic [31:0] mem [32];
  logic [31:0] lcg_state = 32'h4569_7910;
  // Bus model state
  int unsigned req_addr_q [$];
  int          req_due_q [$];
  int          last_due = 0;
  logic [31:0] pf_addr = '0;
  int          cycle_cnt = 0;
  // Reference model and bookkeeping
  logic [31:0] exp_addr;
  int          err_word = -1;
  int          stall_pct = 0;
  int          row_idx = 0;
  int          row_checks, row_errors;
  int          checks = 0;
  int          errors = 0;

  always #5 clk = ~clk;

  align_buf_top dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .ctrl_i        (ctrl_i),
    .branch_addr_i (branch_addr_i),
    .fetch_valid_o (fetch_valid_o),
    .fetch_ready_i (fetch_ready_i),
    .resp_valid_i  (resp_valid_i),
    .resp_i        (resp_i),
    .instr_valid_o (instr_valid_o),
    .instr_ready_i (instr_ready_i),
    .instr_o       (instr_o),
    .instr_addr_o  (instr_addr_o)
  );

  //////////////////////////////
  // Random numbers and memory
  //////////////////////////////

  function automatic logic [31:0] rand_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Low bits per halfword; the first 12 words hold only 32-bit code
  function automatic logic [1:0] half_code(input int h);
    if ((h < 24) || (((h * 3) % 7) >= 3)) begin
      return 2'b11;
    end
    return 2'(h % 3);
  endfunction

  task automatic fill_memory();
    logic [31:0] w;
    for (int i = 0; i < 32; i++) begin
      w = rand_next();
      w[1:0]   = half_code(2 * i);
      w[17:16] = half_code(2 * i + 1);
      mem[i]   = w;
    end
  endtask

  function automatic logic [15:0] mem_half(input logic [31:0] a);
    logic [31:0] w;
    w = mem[a[6:2]];
    return a[1] ? w[31:16] : w[15:0];
  endfunction

  function automatic logic mem_err(input logic [31:0] a);
    return int'(a[6:2]) == err_word;
  endfunction

  task automatic set_row(input int i, input string name, input logic [31:0] target,
                         input int count, input int stall, input int err_idx);
    rows[i].name     = name;
    rows[i].target   = target;
    rows[i].count    = count;
    rows[i].stall    = stall;
    rows[i].err_word = err_idx;
  endtask

  //////////////////////////////
  // Reference check
  //////////////////////////////

  // Full instruction takes the halfword above it, possibly from the next word
  task automatic check_instr();
    logic [31:0] exp_data;
    logic [31:0] mask;
    logic [15:0] low_half;
    logic        exp_err;
    logic        full;
    low_half = mem_half(exp_addr);
    full     = (low_half[1:0] == 2'b11);
    exp_data = {full ? mem_half(exp_addr + 32'd2) : 16'h0, low_half};
    exp_err  = mem_err(exp_addr) || (full && mem_err(exp_addr + 32'd2));
    mask     = full ? 32'hFFFF_FFFF : 32'h0000_FFFF;
    checks++;
    row_checks++;
    assert (instr_addr_o == exp_addr) else begin
      $display("mismatch %s addr expected %h actual %h", rows[row_idx].name,
               exp_addr, instr_addr_o);
      errors++;
      row_errors++;
    end
    assert ((instr_o.rdata & mask) == exp_data) else begin
      $display("mismatch %s data at %h expected %h actual %h", rows[row_idx].name,
               exp_addr, exp_data, instr_o.rdata & mask);
      errors++;
      row_errors++;
    end
    assert (instr_o.err == exp_err) else begin
      $display("mismatch %s err at %h expected %b actual %b", rows[row_idx].name,
               exp_addr, exp_err, instr_o.err);
      errors++;
      row_errors++;
    end
    exp_addr = exp_addr + (full ? 32'd4 : 32'd2);
  endtask

  //////////////////////////////
  // One clock cycle
  //////////////////////////////

  // Drive on the falling edge, sample just before the rising edge
  task automatic step_cycle(input logic do_branch, input logic [31:0] target);
    int lat;
    int due;
    @(negedge clk);
    cycle_cnt++;
    ctrl_i.instr_req = 1'b1;
    ctrl_i.pc_set    = do_branch;
    ctrl_i.kill_if   = do_branch;
    branch_addr_i    = target;
    if (do_branch) begin
      pf_addr = target & 32'hFFFF_FFFC;
    end
    resp_valid_i = 1'b0;
    resp_i       = '0;
    if ((req_due_q.size() != 0) && (req_due_q[0] <= cycle_cnt)) begin
      resp_valid_i = 1'b1;
      resp_i.rdata = mem[req_addr_q[0][6:2]];
      resp_i.err   = mem_err(req_addr_q[0]);
      void'(req_due_q.pop_front());
      void'(req_addr_q.pop_front());
    end
    instr_ready_i = (int'(rand_next() % 32'd100) >= stall_pct);
    #4;
    if (fetch_valid_o && fetch_ready_i) begin
      lat = 1 + int'(rand_next() % 32'd3);
      due = cycle_cnt + lat;
      // Keep responses in order and one per cycle
      if (due <= last_due) begin
        due = last_due + 1;
      end
      last_due = due;
      req_due_q.push_back(due);
      req_addr_q.push_back(pf_addr);
      pf_addr = pf_addr + 32'd4;
      assert (req_due_q.size() <= 2) else begin
        $display("more than two fetch requests in flight in %s", rows[row_idx].name);
        errors++;
        row_errors++;
      end
    end
    if (instr_valid_o && instr_ready_i) begin
      check_instr();
    end
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    rst_n         = 1'b0;
    ctrl_i        = '0;
    branch_addr_i = '0;
    fetch_ready_i = 1'b1;
    resp_valid_i  = 1'b0;
    resp_i        = '0;
    instr_ready_i = 1'b0;
    fill_memory();
    // Name, target, instructions, stall percent, err word
    set_row(0, "aligned_run", 32'h0000_0000, 12, 0, -1);
    set_row(1, "mixed_straddle", 32'h0000_0030, 24, 0, -1);
    set_row(2, "unaligned_target", 32'h0000_0042, 16, 0, -1);
    set_row(3, "branch_in_flight", 32'h0000_003A, 3, 0, -1);
    set_row(4, "err_word", 32'h0000_0036, 20, 0, 17);
    set_row(5, "backpressure", 32'h0000_0052, 30, 50, 20);
    set_row(6, "backpressure_aligned", 32'h0000_0004, 10, 70, 2);
    repeat (10) @(negedge clk);
    rst_n = 1'b1;

    // Every row starts with a branch, which redirects the row before it
    for (int i = 0; i < N_ROWS; i++) begin
      row_idx    = i;
      stall_pct  = rows[i].stall;
      err_word   = rows[i].err_word;
      exp_addr   = rows[i].target;
      row_checks = 0;
      row_errors = 0;
      step_cycle(1'b1, rows[i].target);
      while (row_checks < rows[i].count) begin
        step_cycle(1'b0, rows[i].target);
      end
      $display("row %0d %s: %0d checks, %0d errors", i, rows[i].name,
               row_checks, row_errors);
    end

    $display("rows %0d, checks %0d, errors %0d", N_ROWS, checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // Watchdog allows 40 cycles per checked instruction
  initial begin
    int total;
    total = 0;
    @(posedge rst_n);
    foreach (rows[i]) begin
      total += rows[i].count;
    end
    repeat (total * 40 + 20) @(posedge clk);
    $display("timeout: no progress within %0d cycles", total * 40 + 20);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule : align_buf_tb

`default_nettype wire

//--- vlog.f
hw/fetch_pkg.sv
hw/ctrl_pkg.sv
hw/fetch_ctrl.sv
hw/resp_fifo.sv
hw/instr_aligner.sv
hw/align_buf_top.sv
tb/align_buf_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the alignment buffer testbench with Verilator
# Exit status is zero only when the log holds the pass message

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module align_buf_tb -f vlog.f \
  && ./obj_dir/Valign_buf_tb > sim.log 2>&1
cat sim.log 2>/dev/null

grep -q "TESTBENCH PASSED" sim.log 2>/dev/null && echo "run_sim: pass" \
  || { echo "run_sim: fail"; exit 1; }
